// ==== Makefile ====
TOP := tb_periph_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee run.log
	grep -q "^Everything OK$$" run.log

clean:
	rm -rf obj_dir run.log

// ==== periph_bus_if.sv ====
// --------------------------------------------------------------------------
// register bus between the address decoder and one peripheral
// --------------------------------------------------------------------------

`timescale 1ns/1ps

interface periph_bus_if;

    // local register index inside the peripheral
    periph_map_pkg::offset_t offset;
    logic [7:0]              wdata;
    // write strobe, already qualified by sel
    logic                    wr;
    logic                    sel;
    // zero whenever sel is low
    logic [7:0]              rdata;

    modport ctrl (
        output offset,
        output wdata,
        output wr,
        output sel,
        input  rdata
    );

    modport dev (
        input  offset,
        input  wdata,
        input  wr,
        input  sel,
        output rdata
    );

endinterface

// ==== periph_decoder.sv ====
// --------------------------------------------------------------------------
// address decoder: window match, per-peripheral selects and local offsets,
// read data merge and the hardware info registers
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module periph_decoder #(
    parameter logic [15:0] base_addr  = 16'hFF00,
    parameter int          gpio_width = 16
) (
    input  logic        enable,
    input  logic [15:0] addr,
    input  logic [7:0]  data_in,
    input  logic        write_en,
    output logic [7:0]  data_out,
    periph_bus_if.ctrl  exti_bus,
    periph_bus_if.ctrl  gpio_bus,
    periph_bus_if.ctrl  timer_bus
);

    logic [15:0]             rel;
    logic                    hit;
    logic                    hwi_sel;
    logic                    exti_sel;
    logic                    gpio_sel;
    logic                    timer_sel;
    periph_map_pkg::offset_t hwi_offset;
    logic [7:0]              hwi_rdata;

    function automatic logic in_window(logic [15:0] r, int unsigned off, int unsigned size);
        return (r >= 16'(off)) && (r < 16'(off + size));
    endfunction

    // address relative to register 0 of the block
    assign rel = addr - base_addr;
    assign hit = enable && (addr >= base_addr) && (rel < 16'(periph_map_pkg::total_size));

    assign hwi_sel   = hit && in_window(rel, periph_map_pkg::hwi_off, periph_map_pkg::hwi_size);
    assign exti_sel  = hit && in_window(rel, periph_map_pkg::exti_off, periph_map_pkg::exti_size);
    assign gpio_sel  = hit && in_window(rel, periph_map_pkg::gpio_off, periph_map_pkg::gpio_size);
    assign timer_sel = hit && in_window(rel, periph_map_pkg::timer_off, periph_map_pkg::timer_size);

    assign hwi_offset = periph_map_pkg::offset_t'(rel - 16'(periph_map_pkg::hwi_off));

    assign exti_bus.sel    = exti_sel;
    assign exti_bus.offset = periph_map_pkg::offset_t'(rel - 16'(periph_map_pkg::exti_off));
    assign exti_bus.wdata  = data_in;
    assign exti_bus.wr     = write_en && exti_sel;

    assign gpio_bus.sel    = gpio_sel;
    assign gpio_bus.offset = periph_map_pkg::offset_t'(rel - 16'(periph_map_pkg::gpio_off));
    assign gpio_bus.wdata  = data_in;
    assign gpio_bus.wr     = write_en && gpio_sel;

    assign timer_bus.sel    = timer_sel;
    assign timer_bus.offset = periph_map_pkg::offset_t'(rel - 16'(periph_map_pkg::timer_off));
    assign timer_bus.wdata  = data_in;
    assign timer_bus.wr     = write_en && timer_sel;

    // id and config are constants, read only
    always_comb
    begin
        hwi_rdata = '0;
        if (hwi_sel)
        begin
            case (hwi_offset)
                periph_reg_pkg::hwi_id_reg:     hwi_rdata = periph_reg_pkg::hw_id;
                periph_reg_pkg::hwi_config_reg: hwi_rdata = 8'(gpio_width);
                default:                        hwi_rdata = '0;
            endcase
        end
    end

    assign data_out = hwi_rdata | exti_bus.rdata | gpio_bus.rdata | timer_bus.rdata;

endmodule

// ==== periph_exti.sv ====
// --------------------------------------------------------------------------
// interrupt controller: event flags, mask, masked cpu interrupt lines
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module periph_exti (
    input  logic                                 clk,
    input  logic                                 arst_n,
    periph_bus_if.dev                            bus,
    input  logic                                 gpio_event,
    input  logic                                 timer_event,
    output logic [periph_reg_pkg::irq_count-1:0] ext_int
);

    logic [periph_reg_pkg::irq_count-1:0] flags_q;
    logic [periph_reg_pkg::irq_count-1:0] mask_q;
    logic [periph_reg_pkg::irq_count-1:0] events;
    logic [periph_reg_pkg::irq_count-1:0] clr;

    // one bit per source
    always_comb
    begin
        events = '0;
        events[periph_reg_pkg::irq_gpio]  = gpio_event;
        events[periph_reg_pkg::irq_timer] = timer_event;
    end

    // write one to clear
    always_comb
    begin
        clr = '0;
        if (bus.wr && (bus.offset == periph_reg_pkg::exti_flags_reg))
        begin
            clr = bus.wdata[periph_reg_pkg::irq_count-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            flags_q <= '0;
            mask_q  <= '0;
        end
        else
        begin
            // a new event beats a clear in the same cycle
            flags_q <= (flags_q & ~clr) | events;
            if (bus.wr && (bus.offset == periph_reg_pkg::exti_mask_reg))
            begin
                mask_q <= bus.wdata[periph_reg_pkg::irq_count-1:0];
            end
        end
    end

    assign ext_int = flags_q & mask_q;

    always_comb
    begin
        bus.rdata = '0;
        if (bus.sel)
        begin
            case (bus.offset)
                periph_reg_pkg::exti_flags_reg: bus.rdata = 8'(flags_q);
                periph_reg_pkg::exti_mask_reg:  bus.rdata = 8'(mask_q);
                default:                        bus.rdata = '0;
            endcase
        end
    end

endmodule

// ==== periph_gpio.sv ====
// --------------------------------------------------------------------------
// gpio: output and irq enable registers, input synchronizer, edge events
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module periph_gpio #(
    parameter int gpio_width = 16
) (
    input  logic                  clk,
    input  logic                  arst_n,
    periph_bus_if.dev             bus,
    input  logic [gpio_width-1:0] gpi,
    output logic [gpio_width-1:0] gpo,
    output logic                  gpio_event
);

    logic [gpio_width-1:0] out_q;
    logic [gpio_width-1:0] irq_en_q;
    logic [gpio_width-1:0] sync1_q;
    logic [gpio_width-1:0] sync2_q;
    logic [gpio_width-1:0] prev_q;
    logic [gpio_width-1:0] rise;
    logic [15:0]           out_w;
    logic [15:0]           in_w;
    logic [15:0]           irq_en_w;

    // zero-extended 16-bit views, unused pins read as zero
    assign out_w    = 16'(out_q);
    assign in_w     = 16'(sync2_q);
    assign irq_en_w = 16'(irq_en_q);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_q    <= '0;
            irq_en_q <= '0;
        end
        else if (bus.wr)
        begin
            case (bus.offset)
                periph_reg_pkg::gpio_out_lo:    out_q    <= gpio_width'({out_w[15:8], bus.wdata});
                periph_reg_pkg::gpio_out_hi:    out_q    <= gpio_width'({bus.wdata, out_w[7:0]});
                periph_reg_pkg::gpio_irq_en_lo: irq_en_q <= gpio_width'({irq_en_w[15:8], bus.wdata});
                periph_reg_pkg::gpio_irq_en_hi: irq_en_q <= gpio_width'({bus.wdata, irq_en_w[7:0]});
                default: ;
            endcase
        end
    end

    // two-flop synchronizer plus one stage of history for edge detection
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sync1_q    <= '0;
            sync2_q    <= '0;
            prev_q     <= '0;
            gpio_event <= 1'b0;
        end
        else
        begin
            sync1_q    <= gpi;
            sync2_q    <= sync1_q;
            prev_q     <= sync2_q;
            gpio_event <= |rise;
        end
    end

    assign rise = sync2_q & ~prev_q & irq_en_q;

    always_comb
    begin
        bus.rdata = '0;
        if (bus.sel)
        begin
            case (bus.offset)
                periph_reg_pkg::gpio_out_lo:    bus.rdata = out_w[7:0];
                periph_reg_pkg::gpio_out_hi:    bus.rdata = out_w[15:8];
                periph_reg_pkg::gpio_in_lo:     bus.rdata = in_w[7:0];
                periph_reg_pkg::gpio_in_hi:     bus.rdata = in_w[15:8];
                periph_reg_pkg::gpio_irq_en_lo: bus.rdata = irq_en_w[7:0];
                periph_reg_pkg::gpio_irq_en_hi: bus.rdata = irq_en_w[15:8];
                default:                        bus.rdata = '0;
            endcase
        end
    end

    assign gpo = out_q;

endmodule

// ==== periph_map_pkg.sv ====
// --------------------------------------------------------------------------
// memory map of the peripheral block: register counts, offsets, total size
// and the local offset width and type
// --------------------------------------------------------------------------

package periph_map_pkg;

    // registers per block
    localparam int unsigned hwi_size   = 2;
    localparam int unsigned exti_size  = 2;
    localparam int unsigned gpio_size  = 6;
    localparam int unsigned timer_size = 3;

    // first register of each block, relative to base_addr
    localparam int unsigned hwi_off   = 0;
    localparam int unsigned exti_off  = hwi_off + hwi_size;
    localparam int unsigned gpio_off  = exti_off + exti_size;
    localparam int unsigned timer_off = gpio_off + gpio_size;

    localparam int unsigned total_size = hwi_size + exti_size + gpio_size + timer_size;

    // enough bits to index every register of the block
    localparam int unsigned offset_width = $clog2(total_size);

    typedef logic [offset_width-1:0] offset_t;

endpackage

// ==== periph_reg_pkg.sv ====
// --------------------------------------------------------------------------
// register indices, field positions, interrupt numbering and hw info id
// --------------------------------------------------------------------------

package periph_reg_pkg;

    // hardware info
    localparam periph_map_pkg::offset_t hwi_id_reg     = periph_map_pkg::offset_t'(0);
    localparam periph_map_pkg::offset_t hwi_config_reg = periph_map_pkg::offset_t'(1);
    localparam logic [7:0] hw_id = 8'hA5;

    // interrupt controller
    localparam periph_map_pkg::offset_t exti_flags_reg = periph_map_pkg::offset_t'(0);
    localparam periph_map_pkg::offset_t exti_mask_reg  = periph_map_pkg::offset_t'(1);
    localparam int unsigned irq_gpio  = 0;
    localparam int unsigned irq_timer = 1;
    localparam int unsigned irq_count = 2;

    // gpio
    localparam periph_map_pkg::offset_t gpio_out_lo    = periph_map_pkg::offset_t'(0);
    localparam periph_map_pkg::offset_t gpio_out_hi    = periph_map_pkg::offset_t'(1);
    localparam periph_map_pkg::offset_t gpio_in_lo     = periph_map_pkg::offset_t'(2);
    localparam periph_map_pkg::offset_t gpio_in_hi     = periph_map_pkg::offset_t'(3);
    localparam periph_map_pkg::offset_t gpio_irq_en_lo = periph_map_pkg::offset_t'(4);
    localparam periph_map_pkg::offset_t gpio_irq_en_hi = periph_map_pkg::offset_t'(5);

    // timer
    localparam periph_map_pkg::offset_t timer_ctrl_reg  = periph_map_pkg::offset_t'(0);
    localparam periph_map_pkg::offset_t timer_reload_lo = periph_map_pkg::offset_t'(1);
    localparam periph_map_pkg::offset_t timer_reload_hi = periph_map_pkg::offset_t'(2);
    localparam int unsigned timer_ctrl_run = 0;

endpackage

// ==== periph_subsystem.sv ====
// --------------------------------------------------------------------------
// peripheral block top level: decoder, gpio, timer and interrupt controller
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module periph_subsystem #(
    parameter logic [15:0] base_addr  = 16'hFF00,
    parameter int          gpio_width = 16
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 enable,
    input  logic [15:0]                          addr,
    input  logic [7:0]                           data_in,
    input  logic                                 write_en,
    output logic [7:0]                           data_out,
    input  logic [15:0]                          gpi,
    output logic [15:0]                          gpo,
    output logic [periph_reg_pkg::irq_count-1:0] ext_int
);

    logic                  gpio_event;
    logic                  timer_event;
    logic [gpio_width-1:0] gpo_pins;

    periph_bus_if exti_bus ();
    periph_bus_if gpio_bus ();
    periph_bus_if timer_bus ();

    periph_decoder #(
        .base_addr  (base_addr),
        .gpio_width (gpio_width)
    ) u_decoder (
        .enable    (enable),
        .addr      (addr),
        .data_in   (data_in),
        .write_en  (write_en),
        .data_out  (data_out),
        .exti_bus  (exti_bus),
        .gpio_bus  (gpio_bus),
        .timer_bus (timer_bus)
    );

    periph_gpio #(
        .gpio_width (gpio_width)
    ) u_gpio (
        .clk        (clk),
        .arst_n     (arst_n),
        .bus        (gpio_bus),
        .gpi        (gpi[gpio_width-1:0]),
        .gpo        (gpo_pins),
        .gpio_event (gpio_event)
    );

    // pins above gpio_width stay low
    assign gpo = 16'(gpo_pins);

    periph_timer u_timer (
        .clk         (clk),
        .arst_n      (arst_n),
        .bus         (timer_bus),
        .timer_event (timer_event)
    );

    periph_exti u_exti (
        .clk         (clk),
        .arst_n      (arst_n),
        .bus         (exti_bus),
        .gpio_event  (gpio_event),
        .timer_event (timer_event),
        .ext_int     (ext_int)
    );

endmodule

// ==== periph_timer.sv ====
// --------------------------------------------------------------------------
// timer: run control, 16-bit reload register and reloading down-counter
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module periph_timer (
    input  logic      clk,
    input  logic      arst_n,
    periph_bus_if.dev bus,
    output logic      timer_event
);

    logic        run_q;
    logic        loaded_q;
    logic [15:0] reload_q;
    logic [15:0] count_q;
    logic        ctrl_wr;

    assign ctrl_wr = bus.wr && (bus.offset == periph_reg_pkg::timer_ctrl_reg);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            reload_q <= '0;
        end
        else if (bus.wr)
        begin
            case (bus.offset)
                periph_reg_pkg::timer_reload_lo: reload_q[7:0]  <= bus.wdata;
                periph_reg_pkg::timer_reload_hi: reload_q[15:8] <= bus.wdata;
                default: ;
            endcase
        end
    end

    // any ctrl write restarts from reload on the next cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            run_q       <= 1'b0;
            loaded_q    <= 1'b0;
            count_q     <= '0;
            timer_event <= 1'b0;
        end
        else
        begin
            timer_event <= 1'b0;
            if (ctrl_wr)
            begin
                run_q    <= bus.wdata[periph_reg_pkg::timer_ctrl_run];
                loaded_q <= 1'b0;
            end
            else if (run_q)
            begin
                if (!loaded_q)
                begin
                    count_q  <= reload_q;
                    loaded_q <= 1'b1;
                end
                else if (count_q == 16'd0)
                begin
                    // terminal count, period is reload + 1
                    count_q     <= reload_q;
                    timer_event <= 1'b1;
                end
                else
                begin
                    count_q <= count_q - 16'd1;
                end
            end
        end
    end

    always_comb
    begin
        bus.rdata = '0;
        if (bus.sel)
        begin
            case (bus.offset)
                periph_reg_pkg::timer_ctrl_reg:  bus.rdata[periph_reg_pkg::timer_ctrl_run] = run_q;
                periph_reg_pkg::timer_reload_lo: bus.rdata = reload_q[7:0];
                periph_reg_pkg::timer_reload_hi: bus.rdata = reload_q[15:8];
                default:                         bus.rdata = '0;
            endcase
        end
    end

endmodule

// ==== tb_periph_checker.sv ====
// --------------------------------------------------------------------------
// testbench checker: read data compare, gpo and mask models, ext_int
// relation and timer period model, with error and check counts
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_periph_checker #(
    parameter logic [15:0] base_addr = 16'hFF00
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 enable,
    input  logic [15:0]                          addr,
    input  logic [7:0]                           data_in,
    input  logic                                 write_en,
    input  logic [7:0]                           data_out,
    input  logic [15:0]                          gpo,
    input  logic [periph_reg_pkg::irq_count-1:0] ext_int,
    input  logic                                 chk_en,
    input  logic [7:0]                           chk_exp,
    input  logic                                 done,
    output int                                   error_count,
    output int                                   check_count
);

    localparam logic [15:0] a_flags  = base_addr + 16'(periph_map_pkg::exti_off);
    localparam logic [15:0] a_mask   = a_flags + 16'd1;
    localparam logic [15:0] a_out_lo = base_addr + 16'(periph_map_pkg::gpio_off);
    localparam logic [15:0] a_out_hi = a_out_lo + 16'd1;
    localparam logic [15:0] a_rel_lo = base_addr + 16'(periph_map_pkg::timer_off) + 16'd1;
    localparam logic [15:0] a_rel_hi = a_rel_lo + 16'd1;
    // timer flag sets expected during the timer test
    localparam int min_periods = 3;

    logic [15:0]                          gpo_model;
    logic [periph_reg_pkg::irq_count-1:0] mask_model;
    logic [periph_reg_pkg::irq_count-1:0] int_exp;
    logic [15:0]                          reload_model;
    logic                                 tmr_prev;
    logic                                 done_q;
    int                                   tmr_gap;
    int                                   tmr_seen;
    int                                   period;

    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            gpo_model    <= '0;
            mask_model   <= '0;
            reload_model <= '0;
            tmr_prev     <= 1'b0;
            done_q       <= 1'b0;
            tmr_gap      <= -1;
            tmr_seen     <= 0;
            error_count  = 0;
            check_count  = 0;
        end
        else
        begin
            check_count = check_count + 1;
            if (gpo !== gpo_model)
            begin
                $display("[FAIL] gpo exp %h got %h at %0t", gpo_model, gpo, $time);
                error_count = error_count + 1;
            end
            if (chk_en)
            begin
                check_count = check_count + 1;
                if (data_out !== chk_exp)
                begin
                    $display("[FAIL] data_out addr %h exp %h got %h", addr, chk_exp, data_out);
                    error_count = error_count + 1;
                end
            end
            // interrupt lines are the expected flags anded with the mask
            if (chk_en && addr == a_flags)
            begin
                int_exp     = chk_exp[periph_reg_pkg::irq_count-1:0] & mask_model;
                check_count = check_count + 1;
                if (ext_int !== int_exp)
                begin
                    $display("[FAIL] ext_int exp %h got %h", int_exp, ext_int);
                    error_count = error_count + 1;
                end
            end
            if (enable && write_en)
            begin
                case (addr)
                    a_out_lo: gpo_model[7:0]     <= data_in;
                    a_out_hi: gpo_model[15:8]    <= data_in;
                    a_mask:   mask_model         <= data_in[periph_reg_pkg::irq_count-1:0];
                    a_rel_lo: reload_model[7:0]  <= data_in;
                    a_rel_hi: reload_model[15:8] <= data_in;
                    default: ;
                endcase
            end

            // timer flag sets are one reload plus the zero cycle apart
            period   = int'(reload_model) + 1;
            tmr_prev <= ext_int[periph_reg_pkg::irq_timer];
            if (tmr_gap >= 0)
                tmr_gap <= tmr_gap + 1;
            if (ext_int[periph_reg_pkg::irq_timer] && !tmr_prev)
            begin
                if (tmr_gap >= 0)
                begin
                    tmr_seen    <= tmr_seen + 1;
                    check_count = check_count + 1;
                    if (tmr_gap + 1 != period)
                    begin
                        $display("[FAIL] timer_period exp %h got %h", period, tmr_gap + 1);
                        error_count = error_count + 1;
                    end
                end
                tmr_gap <= 0;
            end

            if (done && !done_q)
            begin
                done_q <= 1'b1;
                if (tmr_seen < min_periods)
                begin
                    $display("timer period measured only %0d times, too few", tmr_seen);
                    error_count = error_count + 1;
                end
            end
        end
    end

endmodule

// ==== tb_periph_subsystem.sv ====
// --------------------------------------------------------------------------
// testbench top: clock, reset, stimulus table and its bus driver loop,
// watchdog and closing report
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_periph_subsystem;

    typedef enum logic [1:0] {op_write, op_read, op_gpi, op_wait} op_t;

    // data holds write data, a gpi value or a cycle count
    typedef struct packed {
        op_t         op;
        logic [15:0] addr;
        logic [15:0] data;
        logic [7:0]  exp;
    } entry_t;

    localparam logic [15:0] base     = 16'hFF00;
    localparam logic [15:0] a_cfg    = base + 16'd1;
    localparam logic [15:0] a_flags  = base + 16'(periph_map_pkg::exti_off);
    localparam logic [15:0] a_mask   = a_flags + 16'd1;
    localparam logic [15:0] a_out_lo = base + 16'(periph_map_pkg::gpio_off);
    localparam logic [15:0] a_out_hi = a_out_lo + 16'd1;
    localparam logic [15:0] a_in_lo  = a_out_lo + 16'd2;
    localparam logic [15:0] a_in_hi  = a_out_lo + 16'd3;
    localparam logic [15:0] a_en_lo  = a_out_lo + 16'd4;
    localparam logic [15:0] a_ctrl   = base + 16'(periph_map_pkg::timer_off);
    localparam logic [15:0] a_rel_lo = a_ctrl + 16'd1;
    localparam logic [15:0] a_end    = base + 16'(periph_map_pkg::total_size);

    logic        clk;
    logic        arst_n;
    logic        enable;
    logic [15:0] addr;
    logic [7:0]  data_in;
    logic        write_en;
    logic [7:0]  data_out;
    logic [15:0] gpi;
    logic [15:0] gpo;
    logic [1:0]  ext_int;
    logic        chk_en;
    logic [7:0]  chk_exp;
    logic        done;
    int          error_count;
    int          check_count;
    int          limit;
    entry_t      stim[$];

    periph_subsystem u_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .enable   (enable),
        .addr     (addr),
        .data_in  (data_in),
        .write_en (write_en),
        .data_out (data_out),
        .gpi      (gpi),
        .gpo      (gpo),
        .ext_int  (ext_int)
    );

    tb_periph_checker #(
        .base_addr (base)
    ) u_checker (
        .clk         (clk),
        .arst_n      (arst_n),
        .enable      (enable),
        .addr        (addr),
        .data_in     (data_in),
        .write_en    (write_en),
        .data_out    (data_out),
        .gpo         (gpo),
        .ext_int     (ext_int),
        .chk_en      (chk_en),
        .chk_exp     (chk_exp),
        .done        (done),
        .error_count (error_count),
        .check_count (check_count)
    );

    always #2 clk = ~clk;

    task automatic add_entry(input op_t op, input logic [15:0] a, input logic [15:0] d,
                             input logic [7:0] e);
        stim.push_back(entry_t'{op, a, d, e});
    endtask

    task automatic build_table();
        logic [7:0] lo;
        logic [7:0] hi;
        // hw info, then reads and writes outside the window
        add_entry(op_read, base, 16'h0, 8'hA5);
        add_entry(op_read, a_cfg, 16'h0, 8'h10);
        add_entry(op_read, a_end, 16'h0, 8'h00);
        add_entry(op_read, base - 16'd1, 16'h0, 8'h00);
        add_entry(op_write, a_end, 16'hFF, 8'h00);
        add_entry(op_write, base - 16'd1, 16'hFF, 8'h00);
        add_entry(op_write, 16'h0004, 16'hFF, 8'h00);
        add_entry(op_read, a_out_lo, 16'h0, 8'h00);
        add_entry(op_read, a_en_lo, 16'h0, 8'h00);
        add_entry(op_read, a_mask, 16'h0, 8'h00);
        add_entry(op_read, a_rel_lo, 16'h0, 8'h00);
        add_entry(op_read, a_ctrl, 16'h0, 8'h00);
        for (int k = 0; k < 2; k++)
        begin
            lo = 8'($urandom());
            hi = 8'($urandom());
            add_entry(op_write, a_out_lo, 16'(lo), 8'h00);
            add_entry(op_write, a_out_hi, 16'(hi), 8'h00);
            add_entry(op_read, a_out_lo, 16'h0, lo);
            add_entry(op_read, a_out_hi, 16'h0, hi);
        end
        // gpio inputs, then an edge on the only enabled pin
        add_entry(op_gpi, 16'h0, 16'h1234, 8'h00);
        add_entry(op_wait, 16'h0, 16'd1, 8'h00);
        add_entry(op_read, a_in_lo, 16'h0, 8'h34);
        add_entry(op_read, a_in_hi, 16'h0, 8'h12);
        add_entry(op_write, a_mask, 16'h03, 8'h00);
        add_entry(op_write, a_en_lo, 16'h01, 8'h00);
        add_entry(op_read, a_flags, 16'h0, 8'h00);
        add_entry(op_gpi, 16'h0, 16'h1235, 8'h00);
        add_entry(op_wait, 16'h0, 16'd4, 8'h00);
        add_entry(op_read, a_flags, 16'h0, 8'h01);
        add_entry(op_write, a_flags, 16'h01, 8'h00);
        add_entry(op_read, a_flags, 16'h0, 8'h00);
        add_entry(op_gpi, 16'h0, 16'h1237, 8'h00);
        add_entry(op_wait, 16'h0, 16'd4, 8'h00);
        add_entry(op_read, a_flags, 16'h0, 8'h00);
        // timer with reload 5, flag cleared every third cycle
        add_entry(op_write, a_rel_lo, 16'h05, 8'h00);
        add_entry(op_read, a_rel_lo, 16'h0, 8'h05);
        add_entry(op_write, a_ctrl, 16'h01, 8'h00);
        for (int k = 0; k < 10; k++)
        begin
            add_entry(op_write, a_flags, 16'h02, 8'h00);
            add_entry(op_wait, 16'h0, 16'd2, 8'h00);
        end
        add_entry(op_write, a_ctrl, 16'h00, 8'h00);
        add_entry(op_wait, 16'h0, 16'd2, 8'h00);
        add_entry(op_write, a_flags, 16'h02, 8'h00);
        add_entry(op_wait, 16'h0, 16'd20, 8'h00);
        add_entry(op_read, a_flags, 16'h0, 8'h00);
        // masked gpio flag stays off ext_int until the mask opens
        add_entry(op_write, a_mask, 16'h02, 8'h00);
        add_entry(op_gpi, 16'h0, 16'h1234, 8'h00);
        add_entry(op_wait, 16'h0, 16'd4, 8'h00);
        add_entry(op_gpi, 16'h0, 16'h1235, 8'h00);
        add_entry(op_wait, 16'h0, 16'd4, 8'h00);
        add_entry(op_read, a_flags, 16'h0, 8'h01);
        add_entry(op_write, a_mask, 16'h03, 8'h00);
        add_entry(op_read, a_flags, 16'h0, 8'h01);
        add_entry(op_write, a_flags, 16'h01, 8'h00);
        add_entry(op_read, a_flags, 16'h0, 8'h00);
        add_entry(op_read, a_mask, 16'h0, 8'h03);
        limit = 200;
        foreach (stim[i])
            limit += 1 + ((stim[i].op == op_wait) ? int'(stim[i].data) : 0);
    endtask

    task automatic release_bus();
        enable   = 1'b0;
        write_en = 1'b0;
        chk_en   = 1'b0;
    endtask

    initial
    begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        addr     = '0;
        data_in  = '0;
        gpi      = '0;
        chk_exp  = '0;
        done     = 1'b0;
        limit    = 0;
        release_bus();
        void'($urandom(60));
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        foreach (stim[i])
        begin
            @(negedge clk);
            release_bus();
            case (stim[i].op)
                op_write:
                begin
                    enable   = 1'b1;
                    write_en = 1'b1;
                    addr     = stim[i].addr;
                    data_in  = stim[i].data[7:0];
                end
                op_read:
                begin
                    enable  = 1'b1;
                    addr    = stim[i].addr;
                    chk_en  = 1'b1;
                    chk_exp = stim[i].exp;
                end
                op_gpi:  gpi = stim[i].data;
                default: repeat (int'(stim[i].data) - 1) @(negedge clk);
            endcase
        end
        @(negedge clk);
        release_bus();
        done = 1'b1;
        repeat (2) @(negedge clk);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // watchdog
    initial
    begin
        wait (limit != 0);
        repeat (limit) @(posedge clk);
        $display("timeout: the stimulus table did not finish within %0d cycles", limit);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
periph_map_pkg.sv
periph_reg_pkg.sv
periph_bus_if.sv
periph_decoder.sv
periph_gpio.sv
periph_timer.sv
periph_exti.sv
periph_subsystem.sv
tb_periph_checker.sv
tb_periph_subsystem.sv
